// File: hw/padframe_pkg.sv
package padframe_pkg;

  //////////////////////////////////////////////////
  // Dimensions
  //////////////////////////////////////////////////

  localparam int unsigned NumPads     = 4;
  localparam int unsigned AddrWidth   = 4;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned PadIdxWidth = $clog2(NumPads);

  // Two words per channel, anything at or above this is unmapped
  localparam logic [AddrWidth-1:0] NumRegWords = AddrWidth'(2 * NumPads);

  //////////////////////////////////////////////////
  // Register fields
  //////////////////////////////////////////////////

  // Configuration word, even address
  localparam int unsigned CfgOutBit   = 0;
  localparam int unsigned CfgOeBit    = 1;
  localparam int unsigned CfgIrqEnBit = 2;
  localparam int unsigned CfgEdgeBit  = 3;

  // Status word, odd address; pending is write-one-to-clear
  localparam int unsigned StatLevelBit = 0;
  localparam int unsigned StatPendBit  = 1;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 error;
    logic [DataWidth-1:0] rdata;
  } reg_rsp_t;

  // Falling selects the falling edge, else rising
  typedef struct packed {
    logic falling;
    logic irq_en;
    logic oe;
    logic out;
  } pad_cfg_t;

  typedef struct packed {
    logic     cfg_we;
    logic     clr_pend;
    pad_cfg_t cfg;
  } pad_wr_t;

  typedef struct packed {
    pad_cfg_t cfg;
    logic     level;
    logic     pending;
  } pad_stat_t;

endpackage

// File: hw/padframe_reg_decode.sv
module padframe_reg_decode (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  padframe_pkg::reg_req_t                           req_i,
  output padframe_pkg::pad_wr_t [padframe_pkg::NumPads-1:0] wr_o,
  output padframe_pkg::reg_req_t                           rd_req_o
);

  logic [padframe_pkg::PadIdxWidth-1:0] pad_idx;
  logic                                 word_sel;
  logic                                 in_range;
  logic                                 do_write;
  logic [padframe_pkg::NumPads-1:0]     pad_hit;
  padframe_pkg::pad_cfg_t               wr_cfg;

  //////////////////////////////////////////////////
  // Address split
  //////////////////////////////////////////////////

  // Bit 0 picks config or status, the bits above it pick the channel
  assign word_sel = req_i.addr[0];
  assign pad_idx  = req_i.addr[padframe_pkg::PadIdxWidth:1];
  assign in_range = req_i.addr < padframe_pkg::NumRegWords;
  assign do_write = req_i.valid && req_i.write && in_range;

  always_comb begin
    pad_hit          = '0;
    pad_hit[pad_idx] = 1'b1;
  end

  // Same config payload goes to every channel, only the strobe differs
  always_comb begin
    wr_cfg.out     = req_i.wdata[padframe_pkg::CfgOutBit];
    wr_cfg.oe      = req_i.wdata[padframe_pkg::CfgOeBit];
    wr_cfg.irq_en  = req_i.wdata[padframe_pkg::CfgIrqEnBit];
    wr_cfg.falling = req_i.wdata[padframe_pkg::CfgEdgeBit];
  end

  //////////////////////////////////////////////////
  // Per-channel strobes
  //////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < padframe_pkg::NumPads; p++) begin
      wr_o[p].cfg      = wr_cfg;
      wr_o[p].cfg_we   = do_write && !word_sel && pad_hit[p];
      wr_o[p].clr_pend = do_write && word_sel && pad_hit[p] &&
                         req_i.wdata[padframe_pkg::StatPendBit];
    end
  end

  // Request held one cycle for the readback block
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_req_o.valid <= 1'b0;
    end else begin
      rd_req_o.valid <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_req_o.write <= req_i.write;
    rd_req_o.addr  <= req_i.addr;
    rd_req_o.wdata <= req_i.wdata;
  end

endmodule

// File: hw/padframe_pad_cell.sv
module padframe_pad_cell (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  padframe_pkg::pad_wr_t   wr_i,
  input  logic                    pad_i,
  output logic                    pad_o,
  output logic                    pad_en_o,
  output padframe_pkg::pad_stat_t stat_o
);

  padframe_pkg::pad_cfg_t cfg_q;

  logic sync_meta_q;
  logic sync_level_q;
  logic level_prev_q;
  logic pending_q;

  logic edge_rise;
  logic edge_fall;
  logic edge_hit;

  //////////////////////////////////////////////////
  // Configuration
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else if (wr_i.cfg_we) begin
      cfg_q <= wr_i.cfg;
    end
  end

  // Driver side of the pin
  assign pad_o    = cfg_q.out;
  assign pad_en_o = cfg_q.oe;

  //////////////////////////////////////////////////
  // Input synchronizer and edge detect
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_meta_q  <= 1'b0;
      sync_level_q <= 1'b0;
      level_prev_q <= 1'b0;
    end else begin
      sync_meta_q  <= pad_i;
      sync_level_q <= sync_meta_q;
      level_prev_q <= sync_level_q;
    end
  end

  assign edge_rise = sync_level_q && !level_prev_q;
  assign edge_fall = !sync_level_q && level_prev_q;
  assign edge_hit  = cfg_q.falling ? edge_fall : edge_rise;

  // Sticky pending flag, a new edge beats a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else if (edge_hit) begin
      pending_q <= 1'b1;
    end else if (wr_i.clr_pend) begin
      pending_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // State to readback
  //////////////////////////////////////////////////

  always_comb begin
    stat_o.cfg     = cfg_q;
    stat_o.level   = sync_level_q;
    stat_o.pending = pending_q;
  end

endmodule

// File: hw/padframe_readback.sv
module padframe_readback (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  input  padframe_pkg::reg_req_t                             rd_req_i,
  input  padframe_pkg::pad_stat_t [padframe_pkg::NumPads-1:0] stat_i,
  output padframe_pkg::reg_rsp_t                             rsp_o,
  output logic                                               irq_o
);

  logic [padframe_pkg::PadIdxWidth-1:0] pad_idx;
  logic                                 word_sel;
  logic                                 in_range;
  logic                                 rd_ok;
  padframe_pkg::pad_stat_t              sel_stat;
  logic [padframe_pkg::DataWidth-1:0]   cfg_word;
  logic [padframe_pkg::DataWidth-1:0]   stat_word;
  logic [padframe_pkg::NumPads-1:0]     irq_vec;

  //////////////////////////////////////////////////
  // Word select
  //////////////////////////////////////////////////

  assign word_sel = rd_req_i.addr[0];
  assign pad_idx  = rd_req_i.addr[padframe_pkg::PadIdxWidth:1];
  assign in_range = rd_req_i.addr < padframe_pkg::NumRegWords;
  assign rd_ok    = rd_req_i.valid && !rd_req_i.write && in_range;
  assign sel_stat = stat_i[pad_idx];

  always_comb begin
    cfg_word                             = '0;
    cfg_word[padframe_pkg::CfgOutBit]   = sel_stat.cfg.out;
    cfg_word[padframe_pkg::CfgOeBit]    = sel_stat.cfg.oe;
    cfg_word[padframe_pkg::CfgIrqEnBit] = sel_stat.cfg.irq_en;
    cfg_word[padframe_pkg::CfgEdgeBit]  = sel_stat.cfg.falling;
  end

  always_comb begin
    stat_word                             = '0;
    stat_word[padframe_pkg::StatLevelBit] = sel_stat.level;
    stat_word[padframe_pkg::StatPendBit]  = sel_stat.pending;
  end

  // Writes and unmapped accesses answer with zero data
  always_comb begin
    rsp_o.valid = rd_req_i.valid;
    rsp_o.error = rd_req_i.valid && !in_range;
    rsp_o.rdata = '0;
    if (rd_ok) begin
      rsp_o.rdata = word_sel ? stat_word : cfg_word;
    end
  end

  //////////////////////////////////////////////////
  // Interrupt combine
  //////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < padframe_pkg::NumPads; p++) begin
      irq_vec[p] = stat_i[p].pending && stat_i[p].cfg.irq_en;
    end
  end

  assign irq_o = |irq_vec;

endmodule

// File: hw/soc_padframe.sv
module soc_padframe (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  padframe_pkg::reg_req_t           reg_req_i,
  output padframe_pkg::reg_rsp_t           reg_rsp_o,
  input  logic [padframe_pkg::NumPads-1:0] pad_i,
  output logic [padframe_pkg::NumPads-1:0] pad_o,
  output logic [padframe_pkg::NumPads-1:0] pad_en_o,
  output logic                             irq_o
);

  padframe_pkg::pad_wr_t   [padframe_pkg::NumPads-1:0] wr;
  padframe_pkg::pad_stat_t [padframe_pkg::NumPads-1:0] stat;
  padframe_pkg::reg_req_t                              rd_req;

  //////////////////////////////////////////////////
  // Register decode
  //////////////////////////////////////////////////

  padframe_reg_decode reg_decode_i (
    .clk_i    ( clk_i     ),
    .rst_n_i  ( rst_n_i   ),
    .req_i    ( reg_req_i ),
    .wr_o     ( wr        ),
    .rd_req_o ( rd_req    )
  );

  //////////////////////////////////////////////////
  // Pad channels
  //////////////////////////////////////////////////

  for (genvar p = 0; p < padframe_pkg::NumPads; p++) begin : g_pad
    padframe_pad_cell pad_cell_i (
      .clk_i    ( clk_i       ),
      .rst_n_i  ( rst_n_i     ),
      .wr_i     ( wr[p]       ),
      .pad_i    ( pad_i[p]    ),
      .pad_o    ( pad_o[p]    ),
      .pad_en_o ( pad_en_o[p] ),
      .stat_o   ( stat[p]     )
    );
  end

  //////////////////////////////////////////////////
  // Response and interrupt
  //////////////////////////////////////////////////

  padframe_readback readback_i (
    .clk_i    ( clk_i     ),
    .rst_n_i  ( rst_n_i   ),
    .rd_req_i ( rd_req    ),
    .stat_i   ( stat      ),
    .rsp_o    ( reg_rsp_o ),
    .irq_o    ( irq_o     )
  );

endmodule

// File: tb/tb_soc_padframe.sv
module tb_soc_padframe;

  localparam int NumRandom   = 12;
  localparam int WatchMargin = 100;

  logic                             clk_i;
  logic                             rst_n_i;
  padframe_pkg::reg_req_t           reg_req_i;
  padframe_pkg::reg_rsp_t           reg_rsp_o;
  logic [padframe_pkg::NumPads-1:0] pad_i;
  logic [padframe_pkg::NumPads-1:0] pad_o;
  logic [padframe_pkg::NumPads-1:0] pad_en_o;
  logic                             irq_o;

  // Vector table
  string                              vec_op    [$];
  logic [padframe_pkg::AddrWidth-1:0] vec_addr  [$];
  logic [padframe_pkg::DataWidth-1:0] vec_data  [$];
  logic [padframe_pkg::DataWidth-1:0] vec_rdata [$];
  logic                               vec_err   [$];
  int                                 n_vec;
  logic                               loaded;

  // Reference model of the pad channels
  padframe_pkg::pad_cfg_t model_cfg   [padframe_pkg::NumPads];
  logic                   model_meta  [padframe_pkg::NumPads];
  logic                   model_level [padframe_pkg::NumPads];
  logic                   model_prev  [padframe_pkg::NumPads];
  logic                   model_pend  [padframe_pkg::NumPads];

  // Request whose response is due in the next step
  padframe_pkg::reg_req_t prev_req;
  padframe_pkg::reg_rsp_t prev_file_rsp;
  logic                   prev_use_model;

  integer seed = 32'hb803_f0cc;
  int     rsp_errs;
  int     pad_errs;
  int     irq_errs;
  int     other_errs;

  soc_padframe soc_padframe_i (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .reg_req_i ( reg_req_i ),
    .reg_rsp_o ( reg_rsp_o ),
    .pad_i     ( pad_i     ),
    .pad_o     ( pad_o     ),
    .pad_en_o  ( pad_en_o  ),
    .irq_o     ( irq_o     )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic void clear_model();
    for (int p = 0; p < padframe_pkg::NumPads; p++) begin
      model_cfg[p]   = '0;
      model_meta[p]  = 1'b0;
      model_level[p] = 1'b0;
      model_prev[p]  = 1'b0;
      model_pend[p]  = 1'b0;
    end
  endfunction

  // One rising edge with the request and pin pattern present at it
  function automatic void apply_edge(input padframe_pkg::reg_req_t req,
                                     input logic [padframe_pkg::NumPads-1:0] pads);
    logic hit;
    logic addr_hit;
    for (int p = 0; p < padframe_pkg::NumPads; p++) begin
      hit = model_cfg[p].falling ? (model_prev[p] && !model_level[p])
                                 : (!model_prev[p] && model_level[p]);
      addr_hit = req.valid && req.write && (req.addr < padframe_pkg::NumRegWords) &&
                 (int'(req.addr >> 1) == p);
      if (hit) begin
        model_pend[p] = 1'b1;
      end else if (addr_hit && req.addr[0] && req.wdata[padframe_pkg::StatPendBit]) begin
        model_pend[p] = 1'b0;
      end
      model_prev[p]  = model_level[p];
      model_level[p] = model_meta[p];
      model_meta[p]  = pads[p];
      if (addr_hit && !req.addr[0]) begin
        model_cfg[p].out     = req.wdata[padframe_pkg::CfgOutBit];
        model_cfg[p].oe      = req.wdata[padframe_pkg::CfgOeBit];
        model_cfg[p].irq_en  = req.wdata[padframe_pkg::CfgIrqEnBit];
        model_cfg[p].falling = req.wdata[padframe_pkg::CfgEdgeBit];
      end
    end
  endfunction

  function automatic padframe_pkg::reg_rsp_t expect_rsp(input padframe_pkg::reg_req_t req);
    padframe_pkg::reg_rsp_t rsp;
    int                     idx;
    rsp = '0;
    idx = int'(req.addr >> 1);
    if (req.valid) begin
      rsp.valid = 1'b1;
      if (req.addr >= padframe_pkg::NumRegWords) begin
        rsp.error = 1'b1;
      end else if (!req.write && req.addr[0]) begin
        rsp.rdata[padframe_pkg::StatLevelBit] = model_level[idx];
        rsp.rdata[padframe_pkg::StatPendBit]  = model_pend[idx];
      end else if (!req.write) begin
        rsp.rdata[padframe_pkg::CfgOutBit]   = model_cfg[idx].out;
        rsp.rdata[padframe_pkg::CfgOeBit]    = model_cfg[idx].oe;
        rsp.rdata[padframe_pkg::CfgIrqEnBit] = model_cfg[idx].irq_en;
        rsp.rdata[padframe_pkg::CfgEdgeBit]  = model_cfg[idx].falling;
      end
    end
    return rsp;
  endfunction

  function automatic logic expect_irq();
    logic irq;
    irq = 1'b0;
    for (int p = 0; p < padframe_pkg::NumPads; p++) begin
      irq = irq | (model_pend[p] & model_cfg[p].irq_en);
    end
    return irq;
  endfunction

  function automatic padframe_pkg::reg_req_t make_req(
      input logic write, input logic [padframe_pkg::AddrWidth-1:0] addr,
      input logic [padframe_pkg::DataWidth-1:0] wdata);
    padframe_pkg::reg_req_t req;
    req.valid = 1'b1;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    return req;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_rsp(input padframe_pkg::reg_rsp_t got,
                           input padframe_pkg::reg_rsp_t exp);
    if (got !== exp) begin
      $display("** Error reg_rsp_o: got valid %h error %h rdata %h, expected %h %h %h (t=%0t)",
               got.valid, got.error, got.rdata, exp.valid, exp.error, exp.rdata, $time);
      rsp_errs++;
    end
  endtask

  task automatic check_pads(input logic [padframe_pkg::NumPads-1:0] got_out,
                            input logic [padframe_pkg::NumPads-1:0] got_en,
                            input logic [padframe_pkg::NumPads-1:0] exp_out,
                            input logic [padframe_pkg::NumPads-1:0] exp_en);
    if (got_out !== exp_out) begin
      $display("** Error pad_o: got %h expected %h (t=%0t)", got_out, exp_out, $time);
      pad_errs++;
    end
    if (got_en !== exp_en) begin
      $display("** Error pad_en_o: got %h expected %h (t=%0t)", got_en, exp_en, $time);
      pad_errs++;
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error irq_o: got %h expected %h (t=%0t)", got, exp, $time);
      irq_errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // One clock cycle with the previous request answered mid-cycle
  task automatic run_step(input padframe_pkg::reg_req_t req,
                          input logic [padframe_pkg::NumPads-1:0] pads,
                          input logic use_model, input padframe_pkg::reg_rsp_t file_rsp);
    padframe_pkg::reg_rsp_t           exp_rsp;
    logic [padframe_pkg::NumPads-1:0] exp_out;
    logic [padframe_pkg::NumPads-1:0] exp_en;
    @(posedge clk_i);
    apply_edge(reg_req_i, pad_i);
    #1;
    reg_req_i = req;
    pad_i     = pads;
    @(negedge clk_i);
    exp_rsp = prev_use_model ? expect_rsp(prev_req) : prev_file_rsp;
    if (exp_rsp.valid && !reg_rsp_o.valid) begin
      $display("No response pulse for the request to address %h (t=%0t)",
               prev_req.addr, $time);
      other_errs++;
    end else begin
      check_rsp(reg_rsp_o, exp_rsp);
    end
    for (int p = 0; p < padframe_pkg::NumPads; p++) begin
      exp_out[p] = model_cfg[p].out;
      exp_en[p]  = model_cfg[p].oe;
    end
    check_pads(pad_o, pad_en_o, exp_out, exp_en);
    check_irq(irq_o, expect_irq());
    prev_req       = req;
    prev_use_model = use_model;
    prev_file_rsp  = file_rsp;
  endtask

  task automatic load_vectors();
    int                                 fd;
    int                                 code;
    string                              line;
    string                              op;
    logic [padframe_pkg::DataWidth-1:0] f_addr;
    logic [padframe_pkg::DataWidth-1:0] f_data;
    logic [padframe_pkg::DataWidth-1:0] f_rdata;
    logic [padframe_pkg::DataWidth-1:0] f_err;
    fd = $fopen("tb/padframe_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/padframe_vectors.txt");
      other_errs++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // Comment lines never parse to five fields
        if (code > 0 && $sscanf(line, "%s %h %h %h %h", op, f_addr, f_data, f_rdata,
                                f_err) == 5) begin
          vec_op.push_back(op);
          vec_addr.push_back(f_addr[padframe_pkg::AddrWidth-1:0]);
          vec_data.push_back(f_data);
          vec_rdata.push_back(f_rdata);
          vec_err.push_back(f_err[0]);
        end
      end
      $fclose(fd);
    end
    n_vec = vec_op.size();
  endtask

  // Watchdog allows eight cycles per vector or random pattern plus a margin
  initial begin
    wait (loaded === 1'b1);
    repeat ((n_vec + NumRandom) * 8 + WatchMargin) @(posedge clk_i);
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    padframe_pkg::reg_req_t           req;
    padframe_pkg::reg_rsp_t           file_rsp;
    logic [padframe_pkg::NumPads-1:0] cur_pads;
    logic [padframe_pkg::DataWidth-1:0] pat;
    logic [padframe_pkg::DataWidth-1:0] clr_word;
    logic [padframe_pkg::DataWidth-1:0] alias_word;
    rst_n_i        = 1'b0;
    reg_req_i      = '0;
    pad_i          = '0;
    loaded         = 1'b0;
    rsp_errs       = 0;
    pad_errs       = 0;
    irq_errs       = 0;
    other_errs     = 0;
    prev_req       = '0;
    prev_file_rsp  = '0;
    prev_use_model = 1'b0;
    cur_pads       = '0;
    clr_word       = '0;
    clr_word[padframe_pkg::StatPendBit] = 1'b1;
    clear_model();
    load_vectors();
    loaded = 1'b1;

    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Directed vectors from the table
    for (int i = 0; i < n_vec; i++) begin
      req = '0;
      pat = vec_data[i];
      if (vec_op[i] == "write") begin
        req = make_req(1'b1, vec_addr[i], vec_data[i]);
      end else if (vec_op[i] == "read") begin
        req = make_req(1'b0, vec_addr[i], '0);
      end else if (vec_op[i] == "pad") begin
        cur_pads = pat[padframe_pkg::NumPads-1:0];
      end else if (vec_op[i] != "idle") begin
        $display("Unknown opcode %s on vector %0d", vec_op[i], i);
        other_errs++;
      end
      file_rsp.valid = req.valid;
      file_rsp.error = vec_err[i];
      file_rsp.rdata = vec_rdata[i];
      run_step(req, cur_pads, 1'b0, file_rsp);
    end

    // Unmapped addresses that alias channel 0, with data that would flip its pins
    alias_word                             = '0;
    alias_word[padframe_pkg::CfgOutBit]   = !model_cfg[0].out;
    alias_word[padframe_pkg::CfgOeBit]    = !model_cfg[0].oe;
    alias_word[padframe_pkg::CfgIrqEnBit] = !model_cfg[0].irq_en;
    alias_word[padframe_pkg::CfgEdgeBit]  = !model_cfg[0].falling;
    run_step(make_req(1'b1, padframe_pkg::NumRegWords, alias_word), cur_pads, 1'b1, '0);
    run_step(make_req(1'b0, padframe_pkg::AddrWidth'(padframe_pkg::NumRegWords + 1), '0),
             cur_pads, 1'b1, '0);
    run_step(make_req(1'b0, '0, '0), cur_pads, 1'b1, '0);

    // Random pin patterns with statuses read back once the pins have settled
    for (int r = 0; r < NumRandom; r++) begin
      pat      = $random(seed);
      cur_pads = pat[padframe_pkg::NumPads-1:0];
      repeat (5) run_step('0, cur_pads, 1'b1, '0);
      for (int p = 0; p < padframe_pkg::NumPads; p++) begin
        run_step(make_req(1'b0, padframe_pkg::AddrWidth'(2 * p + 1), '0), cur_pads, 1'b1, '0);
      end
      run_step(make_req(1'b1, padframe_pkg::AddrWidth'(2 * (r % 4) + 1), clr_word),
               cur_pads, 1'b1, '0);
    end
    run_step('0, cur_pads, 1'b0, '0);

    $display("Errors: response %0d, pads %0d, irq %0d, other %0d",
             rsp_errs, pad_errs, irq_errs, other_errs);
    if (rsp_errs + pad_errs + irq_errs + other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tb/padframe_vectors.txt
# op addr data exp_rdata exp_err
# values in hex; ops are write, read, pad (data is the pin pattern) and idle
read  0 0 0 0
read  1 0 0 0
idle  0 0 0 0
write 0 3 0 0
read  0 0 3 0
write 6 2 0 0
read  6 0 2 0
read  2 0 0 0
pad   0 5 0 0
idle  0 0 0 0
idle  0 0 0 0
read  1 0 3 0
read  5 0 3 0
read  3 0 0 0
write 1 2 0 0
read  1 0 1 0
write 2 c 0 0
pad   0 7 0 0
idle  0 0 0 0
idle  0 0 0 0
read  3 0 1 0
pad   0 5 0 0
idle  0 0 0 0
idle  0 0 0 0
read  3 0 2 0
write 3 2 0 0
read  3 0 0 0
write 8 3 0 1
read  f 0 0 1
read  0 0 3 0
write 4 1 0 0
read  4 0 1 0
read  6 0 2 0
idle  0 0 0 0

// File: project.f
hw/padframe_pkg.sv
hw/padframe_reg_decode.sv
hw/padframe_pad_cell.sv
hw/padframe_readback.sv
hw/soc_padframe.sv
tb/tb_soc_padframe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

top=tb_soc_padframe
build_dir=build

verilator --binary --timing -j 0 \
  -f project.f \
  --top-module "${top}" \
  --Mdir "${build_dir}"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$("./${build_dir}/V${top}" 2>&1)
sim_status=$?
echo "${sim_out}"
if [ ${sim_status} -ne 0 ]; then
  echo "Simulation exited with status ${sim_status}"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" <<< "${sim_out}"; then
  exit 0
fi
exit 1
